/* hdl/ptx_pkg.sv */
package ptx_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  addr_t;
    // Program position for pc, start, end and loopback
    typedef logic [7:0]  index_t;
    typedef logic [7:0]  duration_t;
    typedef logic [3:0]  prescale_t;
    // Upper bit is the output level, lower bit picks the duration variant
    typedef logic [1:0]  symbol_t;
    // Bit 0 timer, bit 1 loop, bit 2 end of program
    typedef logic [2:0]  irq_t;

    localparam int NUM_WORDS = 8;

    // Register map, byte addresses
    localparam addr_t REG_CTRL_ADDR  = 6'd0;
    localparam addr_t REG_INDEX_ADDR = 6'd4;
    localparam addr_t REG_DUR_ADDR   = 6'd8;
    localparam addr_t REG_TIME_ADDR  = 6'd12;
    // Program words sit at 32, 36 ... 60
    localparam addr_t MEM_BASE_ADDR  = 6'd32;

    // Control register; flags themselves live in [2:0]
    localparam int CTRL_START        = 4;
    localparam int CTRL_STOP         = 5;
    localparam int CTRL_IRQ_EN_LSB   = 8;
    localparam int CTRL_LOOP_FOREVER = 12;
    localparam int CTRL_IDLE_LEVEL   = 13;
    localparam int CTRL_INVERT       = 14;
    localparam int CTRL_CARRIER_EN   = 15;
    localparam int CTRL_USE_2BPE     = 16;
    localparam int CTRL_LOW0_LSB     = 17;
    localparam int CTRL_LOW1_LSB     = 19;
    localparam int CTRL_HIGH0_LSB    = 21;
    localparam int CTRL_HIGH1_LSB    = 23;

    // Index register
    localparam int INDEX_START_LSB      = 0;
    localparam int INDEX_END_LSB        = 8;
    localparam int INDEX_LOOPBACK_LSB   = 16;
    localparam int INDEX_LOOP_COUNT_LSB = 24;

    // Duration register, low a/b then high a/b
    localparam int DUR_LOW_A_LSB  = 0;
    localparam int DUR_LOW_B_LSB  = 8;
    localparam int DUR_HIGH_A_LSB = 16;
    localparam int DUR_HIGH_B_LSB = 24;

    // Time register, carrier half period and prescaler exponent
    localparam int TIME_CARRIER_LSB  = 0;
    localparam int TIME_PRESCALE_LSB = 16;

    // Readback word
    localparam int RD_RUNNING  = 4;
    localparam int RD_LOOP_LSB = 8;
    localparam int RD_PC_LSB   = 16;

endpackage

/* hdl/ptx_cfg_if.sv */
`timescale 1ns/10ps

interface ptx_cfg_if #(
    parameter int CARRIER_WIDTH = 12,
    parameter int LOOP_WIDTH    = 8
);
    // Run control
    logic running;
    logic use_2bpe;
    logic loop_forever;
    // 1bpe mappings, first and second half of each element
    ptx_pkg::symbol_t low_map0;
    ptx_pkg::symbol_t low_map1;
    ptx_pkg::symbol_t high_map0;
    ptx_pkg::symbol_t high_map1;
    // Program bounds
    ptx_pkg::index_t start_index;
    ptx_pkg::index_t end_index;
    ptx_pkg::index_t loopback_index;
    logic [LOOP_WIDTH-1:0] loop_count;
    // Symbol timing
    ptx_pkg::duration_t dur_low_a;
    ptx_pkg::duration_t dur_low_b;
    ptx_pkg::duration_t dur_high_a;
    ptx_pkg::duration_t dur_high_b;
    ptx_pkg::prescale_t prescale;
    // Output stage
    logic idle_level;
    logic invert;
    logic carrier_en;
    logic [CARRIER_WIDTH-1:0] carrier_period;

    modport regs (
        output running, use_2bpe, loop_forever,
        output low_map0, low_map1, high_map0, high_map1,
        output start_index, end_index, loopback_index, loop_count,
        output dur_low_a, dur_low_b, dur_high_a, dur_high_b, prescale,
        output idle_level, invert, carrier_en, carrier_period
    );

    modport seq (
        input running, use_2bpe, loop_forever,
        input low_map0, low_map1, high_map0, high_map1,
        input start_index, end_index, loopback_index, loop_count,
        input dur_low_a, dur_low_b, dur_high_a, dur_high_b, prescale
    );

    modport out (
        input running, idle_level, invert, carrier_en, carrier_period
    );

endinterface

/* hdl/ptx_regs.sv */
`timescale 1ns/10ps

module ptx_regs #(
    parameter int CARRIER_WIDTH = 12,
    parameter int LOOP_WIDTH    = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  ptx_pkg::addr_t        address,
    input  ptx_pkg::word_t        wr_data,
    input  logic [2:0]            word_sel,
    input  logic                  symbol_done,
    input  logic                  loop_event,
    input  logic                  program_end,
    input  ptx_pkg::index_t       pc,
    input  logic [LOOP_WIDTH-1:0] loop_counter,
    output ptx_pkg::word_t        rd_data,
    output ptx_pkg::word_t        word,
    output logic                  irq,
    ptx_cfg_if.regs               cfg
);

    localparam int IRQ_W = $bits(ptx_pkg::irq_t);

    logic ctrl_wr;
    logic index_wr;
    logic dur_wr;
    logic time_wr;
    logic mem_wr;
    ptx_pkg::irq_t events;
    ptx_pkg::irq_t flags_clr;

    // Control state
    logic running_q;
    ptx_pkg::irq_t flags_q;
    ptx_pkg::irq_t irq_en_q;
    logic loop_forever_q;
    logic idle_level_q;
    logic invert_q;
    logic carrier_en_q;
    logic use_2bpe_q;
    ptx_pkg::symbol_t low_map0_q;
    ptx_pkg::symbol_t low_map1_q;
    ptx_pkg::symbol_t high_map0_q;
    ptx_pkg::symbol_t high_map1_q;
    ptx_pkg::word_t index_q;
    ptx_pkg::word_t dur_q;
    logic [CARRIER_WIDTH-1:0] carrier_q;
    ptx_pkg::prescale_t prescale_q;

    ptx_pkg::word_t mem [ptx_pkg::NUM_WORDS];

    // Only full 32-bit writes, decoded by exact address
    assign ctrl_wr  = wr_en && (address == ptx_pkg::REG_CTRL_ADDR);
    assign index_wr = wr_en && (address == ptx_pkg::REG_INDEX_ADDR);
    assign dur_wr   = wr_en && (address == ptx_pkg::REG_DUR_ADDR);
    assign time_wr  = wr_en && (address == ptx_pkg::REG_TIME_ADDR);
    assign mem_wr   = wr_en && (address >= ptx_pkg::MEM_BASE_ADDR);

    // Enabled events, timer in bit 0
    assign events    = {program_end, loop_event, symbol_done} & irq_en_q;
    // Write 1 to clear
    assign flags_clr = ctrl_wr ? wr_data[IRQ_W-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q      <= 1'b0;
            flags_q        <= '0;
            irq_en_q       <= '0;
            loop_forever_q <= 1'b0;
            idle_level_q   <= 1'b0;
            invert_q       <= 1'b0;
            carrier_en_q   <= 1'b0;
            use_2bpe_q     <= 1'b0;
            low_map0_q     <= '0;
            low_map1_q     <= '0;
            high_map0_q    <= '0;
            high_map1_q    <= '0;
            index_q        <= '0;
            dur_q          <= '0;
            carrier_q      <= '0;
            prescale_q     <= '0;
        end else begin
            flags_q <= (flags_q & ~flags_clr) | events;
            // Priority is stop, then start, then the end of program
            if (ctrl_wr && wr_data[ptx_pkg::CTRL_STOP]) begin
                running_q <= 1'b0;
            end else if (ctrl_wr && wr_data[ptx_pkg::CTRL_START]) begin
                running_q <= 1'b1;
            end else if (program_end) begin
                running_q <= 1'b0;
            end
            if (ctrl_wr) begin
                irq_en_q       <= wr_data[ptx_pkg::CTRL_IRQ_EN_LSB +: IRQ_W];
                loop_forever_q <= wr_data[ptx_pkg::CTRL_LOOP_FOREVER];
                idle_level_q   <= wr_data[ptx_pkg::CTRL_IDLE_LEVEL];
                invert_q       <= wr_data[ptx_pkg::CTRL_INVERT];
                carrier_en_q   <= wr_data[ptx_pkg::CTRL_CARRIER_EN];
                use_2bpe_q     <= wr_data[ptx_pkg::CTRL_USE_2BPE];
                low_map0_q     <= wr_data[ptx_pkg::CTRL_LOW0_LSB +: 2];
                low_map1_q     <= wr_data[ptx_pkg::CTRL_LOW1_LSB +: 2];
                high_map0_q    <= wr_data[ptx_pkg::CTRL_HIGH0_LSB +: 2];
                high_map1_q    <= wr_data[ptx_pkg::CTRL_HIGH1_LSB +: 2];
            end
            if (index_wr) begin
                index_q <= wr_data;
            end
            if (dur_wr) begin
                dur_q <= wr_data;
            end
            if (time_wr) begin
                carrier_q  <= wr_data[ptx_pkg::TIME_CARRIER_LSB +: CARRIER_WIDTH];
                prescale_q <= wr_data[ptx_pkg::TIME_PRESCALE_LSB +: 4];
            end
        end
    end

    // Program memory, word index from address bits 4:2
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[address[4:2]] <= wr_data;
        end
    end

    assign word = mem[word_sel];
    assign irq  = |flags_q;

    // Readback ignores the address
    always_comb begin
        rd_data = '0;
        rd_data[IRQ_W-1:0] = flags_q;
        rd_data[ptx_pkg::RD_RUNNING] = running_q;
        rd_data[ptx_pkg::RD_LOOP_LSB +: LOOP_WIDTH] = loop_counter;
        rd_data[ptx_pkg::RD_PC_LSB +: 8] = pc;
    end

    assign cfg.running        = running_q;
    assign cfg.use_2bpe       = use_2bpe_q;
    assign cfg.loop_forever   = loop_forever_q;
    assign cfg.low_map0       = low_map0_q;
    assign cfg.low_map1       = low_map1_q;
    assign cfg.high_map0      = high_map0_q;
    assign cfg.high_map1      = high_map1_q;
    assign cfg.start_index    = index_q[ptx_pkg::INDEX_START_LSB +: 8];
    assign cfg.end_index      = index_q[ptx_pkg::INDEX_END_LSB +: 8];
    assign cfg.loopback_index = index_q[ptx_pkg::INDEX_LOOPBACK_LSB +: 8];
    assign cfg.loop_count     = index_q[ptx_pkg::INDEX_LOOP_COUNT_LSB +: LOOP_WIDTH];
    assign cfg.dur_low_a      = dur_q[ptx_pkg::DUR_LOW_A_LSB +: 8];
    assign cfg.dur_low_b      = dur_q[ptx_pkg::DUR_LOW_B_LSB +: 8];
    assign cfg.dur_high_a     = dur_q[ptx_pkg::DUR_HIGH_A_LSB +: 8];
    assign cfg.dur_high_b     = dur_q[ptx_pkg::DUR_HIGH_B_LSB +: 8];
    assign cfg.prescale       = prescale_q;
    assign cfg.idle_level     = idle_level_q;
    assign cfg.invert         = invert_q;
    assign cfg.carrier_en     = carrier_en_q;
    assign cfg.carrier_period = carrier_q;

endmodule

/* hdl/ptx_sequencer.sv */
`timescale 1ns/10ps

module ptx_sequencer #(
    parameter int LOOP_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    ptx_cfg_if.seq                cfg,
    input  ptx_pkg::word_t        word,
    output logic [2:0]            word_sel,
    output logic                  level,
    output logic                  symbol_start,
    output logic                  symbol_done,
    output logic                  loop_event,
    output logic                  program_end,
    output ptx_pkg::index_t       pc,
    output logic [LOOP_WIDTH-1:0] loop_counter
);

    // Longest symbol is 256 << 15 cycles
    localparam int CNT_W = $bits(ptx_pkg::duration_t) + 16;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_LOAD,
        S_RUN
    } state_t;

    state_t state;
    logic half;
    logic fetch_done;
    logic stage_valid;
    ptx_pkg::symbol_t stage_sym;
    ptx_pkg::symbol_t fetch_sym;
    ptx_pkg::symbol_t next_sym;
    ptx_pkg::duration_t next_dur;
    logic [CNT_W-1:0] next_len;
    logic [CNT_W-1:0] count;
    logic in_symbol;
    logic last;
    logic advance;
    logic take;
    logic step;
    logic at_end;
    logic do_loop;

    // Word holding the element at pc
    assign word_sel = pc[7:5];

    always_comb begin
        if (cfg.use_2bpe) begin
            fetch_sym = word[{pc[4:1], 1'b0} +: 2];
        end else if (word[pc[4:0]]) begin
            fetch_sym = half ? cfg.high_map1 : cfg.high_map0;
        end else begin
            fetch_sym = half ? cfg.low_map1 : cfg.low_map0;
        end
    end

    // Staged symbol goes first, otherwise bypass straight from memory
    assign next_sym = stage_valid ? stage_sym : fetch_sym;

    always_comb begin
        case (next_sym)
            2'd0:    next_dur = cfg.dur_low_a;
            2'd1:    next_dur = cfg.dur_low_b;
            2'd2:    next_dur = cfg.dur_high_a;
            default: next_dur = cfg.dur_high_b;
        endcase
    end

    assign next_len = (CNT_W'(next_dur) + CNT_W'(1)) << cfg.prescale;

    assign in_symbol   = cfg.running && (state == S_LOAD || state == S_RUN);
    assign symbol_done = in_symbol && (count == '0);
    // Nothing staged and nothing left to fetch
    assign last        = fetch_done && !stage_valid;
    assign program_end = symbol_done && last;
    assign advance     = (cfg.running && state == S_FETCH) || (symbol_done && !last);
    assign take        = (advance || (in_symbol && !stage_valid)) && !fetch_done;

    // pc moves once per element, so every other symbol in 1bpe
    assign step       = cfg.use_2bpe || half;
    assign at_end     = (pc == cfg.end_index);
    assign do_loop    = cfg.loop_forever || (loop_counter != '0);
    assign loop_event = take && step && at_end && do_loop;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            pc           <= '0;
            loop_counter <= '0;
            half         <= 1'b0;
            fetch_done   <= 1'b0;
            stage_valid  <= 1'b0;
            symbol_start <= 1'b0;
        end else if (!cfg.running || state == S_IDLE) begin
            // Rearm at the start index
            state        <= S_FETCH;
            pc           <= cfg.start_index;
            loop_counter <= cfg.loop_count;
            half         <= 1'b0;
            fetch_done   <= 1'b0;
            stage_valid  <= 1'b0;
            symbol_start <= 1'b0;
        end else begin
            symbol_start <= advance;
            case (state)
                S_FETCH: state <= S_LOAD;
                default: state <= program_end ? S_IDLE : S_RUN;
            endcase
            if (advance && stage_valid && !take) begin
                stage_valid <= 1'b0;
            end else if (take && !advance) begin
                stage_valid <= 1'b1;
            end
            if (take) begin
                half <= ~half;
                if (step) begin
                    if (!at_end) begin
                        pc <= pc + (cfg.use_2bpe ? 8'd2 : 8'd1);
                    end else if (do_loop) begin
                        pc           <= cfg.loopback_index;
                        loop_counter <= loop_counter - 1'b1;
                    end else begin
                        // Last element fetched, let the staged symbols drain
                        fetch_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Symbol payload and duration countdown
    always_ff @(posedge clk) begin
        if (take) begin
            stage_sym <= fetch_sym;
        end
        if (advance) begin
            level <= next_sym[1];
            count <= next_len - CNT_W'(1);
        end else if (in_symbol) begin
            count <= count - CNT_W'(1);
        end
    end

endmodule

/* hdl/ptx_output.sv */
`timescale 1ns/10ps

module ptx_output #(
    parameter int CARRIER_WIDTH = 12
) (
    input  logic   clk,
    input  logic   rst_n,
    ptx_cfg_if.out cfg,
    input  logic   level,
    input  logic   symbol_start,
    output logic   tx_out,
    output logic   tx_valid,
    output logic   carrier_out
);

    logic level_q;
    logic [CARRIER_WIDTH-1:0] carrier_cnt;
    logic modulated;

    // Valid from the first symbol until running drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= cfg.running && (tx_valid || symbol_start);
        end
    end

    always_ff @(posedge clk) begin
        if (symbol_start) begin
            level_q <= level;
        end
    end

    // Carrier toggles every carrier_period + 1 cycles
    // Also cleared once running drops so it goes low together with tx_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carrier_cnt <= '0;
            carrier_out <= 1'b0;
        end else if (!tx_valid || !cfg.running) begin
            carrier_cnt <= '0;
            carrier_out <= 1'b0;
        end else if (carrier_cnt == cfg.carrier_period) begin
            carrier_cnt <= '0;
            carrier_out <= ~carrier_out;
        end else begin
            carrier_cnt <= carrier_cnt + 1'b1;
        end
    end

    assign modulated = cfg.carrier_en ? (level_q & carrier_out) : level_q;
    // Idle level when not valid, inversion applied last
    assign tx_out = (tx_valid ? modulated : cfg.idle_level) ^ cfg.invert;

endmodule

/* hdl/pulse_transmitter.sv */
`timescale 1ns/10ps

module pulse_transmitter #(
    parameter int CARRIER_WIDTH = 12,
    parameter int LOOP_WIDTH    = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  ptx_pkg::addr_t address,
    input  ptx_pkg::word_t data_in,
    input  logic           wr_en,
    output ptx_pkg::word_t data_out,
    output logic           irq,
    output logic           tx_out,
    output logic           tx_valid,
    output logic           carrier_out
);

    logic [2:0] word_sel;
    ptx_pkg::word_t word;
    logic symbol_done;
    logic loop_event;
    logic program_end;
    ptx_pkg::index_t pc;
    logic [LOOP_WIDTH-1:0] loop_counter;
    logic level;
    logic symbol_start;

    ptx_cfg_if #(
        .CARRIER_WIDTH(CARRIER_WIDTH),
        .LOOP_WIDTH(LOOP_WIDTH)
    ) cfg_if ();

    // Bus decode, config and program memory
    ptx_regs #(
        .CARRIER_WIDTH(CARRIER_WIDTH),
        .LOOP_WIDTH(LOOP_WIDTH)
    ) u_regs (
        .clk(clk),
        .rst_n(rst_n),
        .wr_en(wr_en),
        .address(address),
        .wr_data(data_in),
        .word_sel(word_sel),
        .symbol_done(symbol_done),
        .loop_event(loop_event),
        .program_end(program_end),
        .pc(pc),
        .loop_counter(loop_counter),
        .rd_data(data_out),
        .word(word),
        .irq(irq),
        .cfg(cfg_if)
    );

    ptx_sequencer #(
        .LOOP_WIDTH(LOOP_WIDTH)
    ) u_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .cfg(cfg_if),
        .word(word),
        .word_sel(word_sel),
        .level(level),
        .symbol_start(symbol_start),
        .symbol_done(symbol_done),
        .loop_event(loop_event),
        .program_end(program_end),
        .pc(pc),
        .loop_counter(loop_counter)
    );

    ptx_output #(
        .CARRIER_WIDTH(CARRIER_WIDTH)
    ) u_output (
        .clk(clk),
        .rst_n(rst_n),
        .cfg(cfg_if),
        .level(level),
        .symbol_start(symbol_start),
        .tx_out(tx_out),
        .tx_valid(tx_valid),
        .carrier_out(carrier_out)
    );

endmodule

/* tb/ptx_props.sv */
`timescale 1ns/10ps

module ptx_props (
    input logic            clk,
    input logic            rst_n,
    input logic [1:0]      state,
    input logic            running,
    input logic            use_2bpe,
    input logic            symbol_start,
    input logic            symbol_done,
    input logic            program_end,
    input ptx_pkg::index_t pc
);

    // Encoding of the idle state in the sequencer FSM
    localparam logic [1:0] IDLE = 2'd0;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // No symbol strobes while the FSM sits idle
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> !(symbol_start || symbol_done))
        else begin
            fail_count++;
            $error("symbol strobe while the sequencer is idle");
        end

    // End of program lasts one cycle
    end_single: assert property (@(posedge clk) disable iff (!rst_n)
        program_end |=> !program_end)
        else begin
            fail_count++;
            $error("program_end held for more than one cycle");
        end

    // 2bpe elements sit on even positions
    pc_even: assert property (@(posedge clk) disable iff (!rst_n)
        (running && use_2bpe) |-> !pc[0])
        else begin
            fail_count++;
            $error("odd pc while running in 2bpe mode");
        end

endmodule

bind ptx_sequencer ptx_props u_props (
    .clk(clk),
    .rst_n(rst_n),
    .state(state),
    .running(cfg.running),
    .use_2bpe(cfg.use_2bpe),
    .symbol_start(symbol_start),
    .symbol_done(symbol_done),
    .program_end(program_end),
    .pc(pc)
);

/* tb/tb_pulse_transmitter.sv */
`timescale 1ns/10ps

module tb_pulse_transmitter;

    localparam int CLK_PERIOD = 100;
    localparam int MEM_DEPTH  = 512;

    logic clk;
    logic rst_n;
    ptx_pkg::addr_t address;
    ptx_pkg::word_t data_in;
    logic wr_en;
    ptx_pkg::word_t data_out;
    logic irq;
    logic tx_out;
    logic tx_valid;
    logic carrier_out;

    // Flat image of the cases file
    logic [31:0] cases [MEM_DEPTH];
    int limit_cycles = 0;

    pulse_transmitter uut (
        .clk(clk),
        .rst_n(rst_n),
        .address(address),
        .data_in(data_in),
        .wr_en(wr_en),
        .data_out(data_out),
        .irq(irq),
        .tx_out(tx_out),
        .tx_valid(tx_valid),
        .carrier_out(carrier_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    // One 32-bit write after a random idle gap
    task automatic bus_write(input ptx_pkg::addr_t addr, input ptx_pkg::word_t value);
        repeat ($urandom_range(0, 2)) @(posedge clk);
        @(posedge clk);
        address <= addr;
        data_in <= value;
        wr_en   <= 1'b1;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    // Measure tx_out run lengths against the level/length pairs at pos
    task automatic check_runs(input int pos, input int count);
        logic level;
        int len;
        for (int i = 0; i < count; i++) begin
            level = tx_out;
            len = 0;
            while (tx_valid && tx_out == level) begin
                len++;
                @(negedge clk);
            end
            assert (level == cases[pos + 2 * i][0] && len == cases[pos + 2 * i + 1])
                else value_error($sformatf("run %0d is level %0d for %0d, expected %0d for %0d",
                    i, level, len, cases[pos + 2 * i][0], cases[pos + 2 * i + 1]));
        end
    endtask

    task automatic run_case(input int pos);
        ptx_pkg::word_t ctrl;
        ptx_pkg::word_t index;
        ptx_pkg::irq_t exp_flags;
        logic idle_out;
        logic forever_mode;
        logic expect_loop;
        int wait_cycles;
        ctrl = cases[pos];
        index = cases[pos + 1];
        idle_out = ctrl[ptx_pkg::CTRL_IDLE_LEVEL] ^ ctrl[ptx_pkg::CTRL_INVERT];
        forever_mode = ctrl[ptx_pkg::CTRL_LOOP_FOREVER];
        expect_loop = forever_mode || (index[ptx_pkg::INDEX_LOOP_COUNT_LSB +: 8] != 8'd0);
        bus_write(ptx_pkg::REG_INDEX_ADDR, index);
        bus_write(ptx_pkg::REG_DUR_ADDR, cases[pos + 2]);
        bus_write(ptx_pkg::REG_TIME_ADDR, cases[pos + 3]);
        for (int w = 0; w < ptx_pkg::NUM_WORDS; w++) begin
            bus_write(ptx_pkg::addr_t'(ptx_pkg::MEM_BASE_ADDR + 4 * w), cases[pos + 4 + w]);
        end
        // Config first so the idle level shows before the start
        bus_write(ptx_pkg::REG_CTRL_ADDR, ctrl);
        @(negedge clk);
        assert (!tx_valid && tx_out == idle_out)
            else value_error("idle output wrong before start");
        bus_write(ptx_pkg::REG_CTRL_ADDR, ctrl | (32'd1 << ptx_pkg::CTRL_START));
        @(negedge clk);
        assert (data_out[ptx_pkg::RD_RUNNING]
                && data_out[ptx_pkg::RD_PC_LSB +: 8] == index[7:0]
                && data_out[ptx_pkg::RD_LOOP_LSB +: 8]
                   == index[ptx_pkg::INDEX_LOOP_COUNT_LSB +: 8])
            else value_error($sformatf("readback %h after start", data_out));
        wait_cycles = 0;
        while (!tx_valid) begin
            wait_cycles++;
            @(negedge clk);
        end
        assert (wait_cycles == 2)
            else value_error($sformatf("tx_valid rose %0d cycles after running", wait_cycles));
        check_runs(pos + 13, cases[pos + 12]);
        if (forever_mode) begin
            assert (tx_valid) else value_error("tx_valid fell while looping forever");
            bus_write(ptx_pkg::REG_CTRL_ADDR, ctrl | (32'd1 << ptx_pkg::CTRL_STOP));
            @(negedge clk);
            while (tx_valid) @(negedge clk);
        end
        assert (!data_out[ptx_pkg::RD_RUNNING] && tx_out == idle_out && !carrier_out)
            else value_error("transmitter not back to idle after the program");
        // Timer flag from every symbol, end flag only on a natural end
        // Loop flag only when looping, all gated by their enables
        exp_flags = ctrl[ptx_pkg::CTRL_IRQ_EN_LSB +: 3] & {!forever_mode, expect_loop, 1'b1};
        assert (data_out[2:0] == exp_flags && irq == (exp_flags != 3'b000))
            else value_error($sformatf("flags %b after the program, expected %b",
                data_out[2:0], exp_flags));
        bus_write(ptx_pkg::REG_CTRL_ADDR, ctrl | 32'h7);
        @(negedge clk);
        assert (data_out[2:0] == 3'b000 && !irq)
            else value_error("flags not cleared by writing 1");
    endtask

    initial begin
        int pos;
        int num_cases;
        int total;
        clk = 1'b0;
        rst_n = 1'b0;
        address = '0;
        data_in = '0;
        wr_en = 1'b0;
        void'($urandom(30979));
        $readmemh("tb/ptx_cases.txt", cases);
        num_cases = cases[0];
        // Sum of expected symbol cycles sets the watchdog limit
        pos = 1;
        total = 0;
        for (int c = 0; c < num_cases; c++) begin
            for (int r = 0; r < cases[pos + 12]; r++) begin
                total += cases[pos + 14 + 2 * r];
            end
            pos += 13 + 2 * cases[pos + 12];
        end
        limit_cycles = 2 * total + 1000;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (data_out == '0 && !tx_out && !tx_valid && !irq && !carrier_out)
            else value_error("outputs not at reset values");
        pos = 1;
        for (int c = 0; c < num_cases; c++) begin
            run_case(pos);
            pos += 13 + 2 * cases[pos + 12];
        end
        if (uut.u_sequencer.u_props.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("%0d sequencer property checks failed",
                uut.u_sequencer.u_props.fail_count));
        end
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run($sformatf("Timeout: the test did not finish within %0d cycles", limit_cycles));
    end

endmodule

/* all.f */
hdl/ptx_pkg.sv
hdl/ptx_cfg_if.sv
hdl/ptx_regs.sv
hdl/ptx_sequencer.sv
hdl/ptx_output.sv
hdl/pulse_transmitter.sv
tb/ptx_props.sv
tb/tb_pulse_transmitter.sv

/* tb/ptx_cases.txt */
// Pulse transmitter cases, every value in hex
// First token: number of cases. Each case line then holds
// ctrl index dur time w0 w1 w2 w3 w4 w5 w6 w7 nruns, then nruns pairs of level length
// Run lengths are (duration + 1) << prescale, same-level neighbours merged
6
// 2bpe, prescale 0, all four durations, two merged runs
00010700 00000e00 09020603 00000000 71b2 0 0 0 0 0 0 0 6 1 3 0 4 1 d 0 b 1 a 0 7
// 2bpe from word 1, prescale 2, loop count 2 between positions 34 and 38
00010700 02222620 03020100 00020000 0 63 0 0 0 0 0 0 8 1 10 0 4 1 c 0 c 1 c 0 c 1 c 0 8
// 1bpe, prescale 1, bits 1 0 1 1 0 with mappings high 3,0 and low 2,1
006c0700 00000400 03010401 00010000 d 0 0 0 0 0 0 0 a 1 8 0 4 1 4 0 a 1 8 0 4 1 8 0 4 1 4 0 a
// 2bpe, idle level 1 with inversion
00016700 00000600 01050402 00000000 39 0 0 0 0 0 0 0 3 1 5 0 8 1 3
// Carrier period 3 over a high symbol of 16 then a low symbol of 8
00018700 00000200 000f0007 00000003 2 0 0 0 0 0 0 0 5 0 4 1 4 0 4 1 4 0 8
// Loop forever, checked for three passes before the stop write
00011700 00000200 00040002 00000000 2 0 0 0 0 0 0 0 6 1 5 0 3 1 5 0 3 1 5 0 3
